// ==== icache_tests.txt ====
# Columns: op, line address (hex, 29 bits), expected hit (1) or miss (0)
# R = read, F = flush pulse without further columns
R 0000013 0
R 0000013 1
R 0000023 0
R 0000013 1
R 0000023 1
R 0000033 0
R 0000023 1
R 0000033 1
R 0000013 0
R 0000023 0
R 0000013 1
R 0000033 0
R 0000023 1
R 0000033 1
R 1ABCDEA 0
R 1ABCDEA 1
R 0FFFFFA 0
R 0FFFFFA 1
R 1FFFFFFF 0
R 1FFFFFFF 1
F
R 0000023 0
R 0000033 0
R 0000013 0
R 1ABCDEA 0
R 0FFFFFA 0
R 1FFFFFFF 0
R 0000033 1
R 0000023 0
R 0000013 1

// ==== compile.f ====
icache_pkg.sv
icache_sram.sv
icache_mem_ctrl.sv
icache_replace.sv
icache_hit_logic.sv
icache_ctrl_unit.sv
icache_top.sv
tb_clock_gen.sv
tb_icache_checker.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_sram.sv
  - icache_mem_ctrl.sv
  - icache_replace.sv
  - icache_hit_logic.sv
  - icache_ctrl_unit.sv
  - icache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_icache_checker.sv
      - tb_icache.sv

// ==== tb_icache.sv ====
// Testbench top for the L1 instruction cache
// Runs the operations of the tests file and models the next memory level

`timescale 1ns/10ps

module tb_icache;

  import icache_pkg::*;

  localparam int TIMEOUT_CYC = 200;

  logic                     clk, rst;
  logic                     req, flush, busy, resp_valid;
  logic                     mem_req, mem_valid;
  logic [ICACHE_ADDR_W-1:0] req_addr, mem_addr;
  icache_line_t             resp_line, mem_line;
  // Expectation handed to the checker
  logic                     exp_hit;
  logic [ICACHE_ADDR_W-1:0] exp_addr;
  int                       err_cnt;

  logic [31:0]              rand_state;
  logic                     ok, file_bad;
  logic [7:0]               op;
  logic [ICACHE_ADDR_W-1:0] addr;
  string                    text;
  int                       fd, code, hit_val, ops, timeouts, n;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_o(rst));

  icache_top u_icache_top (
    .clk_i(clk), .rst_i(rst), .req_i(req), .req_addr_i(req_addr), .flush_i(flush),
    .busy_o(busy), .resp_valid_o(resp_valid), .resp_line_o(resp_line),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_valid_i(mem_valid), .mem_line_i(mem_line)
  );

  tb_icache_checker u_checker (
    .clk_i(clk), .rst_i(rst), .req_i(req), .flush_i(flush), .exp_hit_i(exp_hit),
    .exp_addr_i(exp_addr), .busy_i(busy), .resp_valid_i(resp_valid), .resp_line_i(resp_line),
    .mem_req_i(mem_req), .mem_addr_i(mem_addr), .mem_valid_i(mem_valid), .err_cnt_o(err_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Address zero-extended in the low word, its inverse in the high word
  function automatic icache_line_t refill_line(input logic [ICACHE_ADDR_W-1:0] a);
    logic [31:0] lo;
    lo = {3'b000, a};
    return {~lo, lo};
  endfunction

  task automatic wait_idle(output logic done);
    int k;
    k = 0;
    while (busy && k < TIMEOUT_CYC) begin
      @(negedge clk);
      k++;
    end
    done = !busy;
    if (!done) begin
      $display("ERROR at %0t: cache still busy after %0d cycles", $time, TIMEOUT_CYC);
      timeouts++;
    end
  endtask

  // One read, answering a refill request after 1 to 8 cycles
  task automatic do_read(input logic [ICACHE_ADDR_W-1:0] a, input logic hit,
                         output logic done);
    int k;
    int countdown;
    logic got;
    logic [ICACHE_ADDR_W-1:0] fill_addr;
    exp_addr  = a;
    exp_hit   = hit;
    req_addr  = a;
    req       = 1'b1;
    k         = 0;
    countdown = -1;
    got       = 1'b0;
    fill_addr = '0;
    while (!got && k < TIMEOUT_CYC) begin
      @(negedge clk);
      k++;
      req       = 1'b0;
      mem_valid = 1'b0;
      if (countdown == 0) begin
        mem_valid = 1'b1;
        mem_line  = refill_line(fill_addr);
      end
      if (countdown >= 0) countdown--;
      if (mem_req) begin
        fill_addr  = mem_addr;
        rand_state = lcg_next(rand_state);
        countdown  = int'(rand_state[18:16]);
      end
      if (resp_valid) got = 1'b1;
    end
    done = got;
    if (!got) begin
      $display("ERROR at %0t: no response to the read of %h within %0d cycles",
               $time, a, TIMEOUT_CYC);
      timeouts++;
    end
  endtask

  task automatic do_flush(output logic done);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_idle(done);
  endtask

  initial begin
    req        = 1'b0;
    req_addr   = '0;
    flush      = 1'b0;
    mem_valid  = 1'b0;
    mem_line   = '0;
    exp_hit    = 1'b0;
    exp_addr   = '0;
    rand_state = 32'hc32f;
    ops        = 0;
    timeouts   = 0;
    file_bad   = 1'b0;
    ok         = 1'b1;
    // Reset, then the reset sweep over all sets
    n = 0;
    while (rst !== 1'b0 && n < TIMEOUT_CYC) begin
      @(posedge clk);
      n++;
    end
    @(negedge clk);
    wait_idle(ok);
    fd = $fopen("icache_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open icache_tests.txt");
      file_bad = 1'b1;
    end else begin
      while (ok && !$feof(fd)) begin
        text = "";
        code = $fgets(text, fd);
        // Skip blank and comment lines
        if (text.len() > 1 && text[0] != "#") begin
          code = $sscanf(text, "%c %h %d", op, addr, hit_val);
          if (op == "R" && code == 3) begin
            do_read(addr, hit_val != 0, ok);
            ops++;
          end else if (op == "F") begin
            do_flush(ok);
            ops++;
          end else begin
            $display("ERROR: unreadable line in tests file: %s", text);
            file_bad = 1'b1;
          end
          if (ok) wait_idle(ok);
        end
      end
      $fclose(fd);
    end
    // Give the checker the last idle sample
    repeat (2) @(negedge clk);
    $display("Summary: %0d operations, %0d check errors, %0d timeouts", ops, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0 && !file_bad && ops > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb_icache_checker.sv ====
// Cache response checker
// Samples the DUT on rising edges and compares with the expected results

`timescale 1ns/10ps

module tb_icache_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Operation start and expectation from the testbench top
  input  logic                                  req_i,
  input  logic                                  flush_i,
  input  logic                                  exp_hit_i,
  input  logic [icache_pkg::ICACHE_ADDR_W-1:0]  exp_addr_i,
  // Observed DUT signals
  input  logic                                  busy_i,
  input  logic                                  resp_valid_i,
  input  icache_pkg::icache_line_t              resp_line_i,
  input  logic                                  mem_req_i,
  input  logic [icache_pkg::ICACHE_ADDR_W-1:0]  mem_addr_i,
  input  logic                                  mem_valid_i,
  output int                                    err_cnt_o
);

  import icache_pkg::*;

  // Operation in flight
  logic                     active;
  logic                     flush_op;
  logic                     hit_q;
  logic [ICACHE_ADDR_W-1:0] addr_q;
  // Refill request seen for this read
  logic                     refill_seen;
  // Busy must be low on the next sample
  logic                     idle_due;
  // Cycles since the request was sampled
  int                       cyc;
  int                       valid_cyc;

  // Next-level memory returns the address in the low word, inverted in the high word
  function automatic icache_line_t line_for_addr(input logic [ICACHE_ADDR_W-1:0] addr);
    logic [31:0] lo;
    lo = {3'b000, addr};
    return {~lo, lo};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("FAILED at %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
    err_cnt_o++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  // Flush keeps busy high for one cycle per set
  task automatic check_flush_cycle();
    if (!busy_i) report_mismatch("busy_o", 1, 0);
    if (resp_valid_i) report_problem("resp_valid_o pulsed during a flush");
    if (mem_req_i) report_problem("mem_req_o pulsed during a flush");
    if (cyc == ICACHE_SETS) begin
      active   = 1'b0;
      idle_due = 1'b1;
    end
  endtask

  task automatic check_read_cycle();
    if (!busy_i) report_mismatch("busy_o", 1, 0);
    if (mem_valid_i) valid_cyc = cyc;
    if (mem_req_i) begin
      if (refill_seen) report_problem("second mem_req_o pulse for one miss");
      refill_seen = 1'b1;
      // Refill where a hit was expected
      if (hit_q) report_mismatch("mem_req_o", 0, 1);
      else if (cyc != 2) report_mismatch("mem_req_o cycle", 2, cyc);
      if (mem_addr_i !== addr_q) report_mismatch("mem_addr_o", addr_q, mem_addr_i);
    end
    if (resp_valid_i) begin
      // Answered straight from the array where a miss was expected
      if (!hit_q && !refill_seen) report_mismatch("mem_req_o", 1, 0);
      if (!refill_seen && cyc != 2) report_mismatch("resp_valid_o cycle", 2, cyc);
      if (refill_seen && cyc != valid_cyc + 1) begin
        report_mismatch("resp_valid_o cycle", valid_cyc + 1, cyc);
      end
      if (resp_line_i !== line_for_addr(addr_q)) begin
        report_mismatch("resp_line_o", line_for_addr(addr_q), resp_line_i);
      end
      active   = 1'b0;
      idle_due = 1'b1;
    end
  endtask

  initial begin
    err_cnt_o = 0;
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      active   = 1'b0;
      idle_due = 1'b0;
    end else begin
      // Busy drops the cycle after the response or the last flushed set
      if (idle_due && busy_i) report_mismatch("busy_o", 0, 1);
      idle_due = 1'b0;
      if (active) begin
        cyc++;
        if (flush_op) check_flush_cycle();
        else check_read_cycle();
      end else begin
        if (resp_valid_i) report_problem("resp_valid_o pulsed without a request");
        if (mem_req_i) report_problem("mem_req_o pulsed without a request");
      end
      // Latch the expectation with the request or flush pulse
      if (req_i || flush_i) begin
        if (active) report_problem("new operation started before the previous one ended");
        active      = 1'b1;
        flush_op    = flush_i;
        hit_q       = exp_hit_i;
        addr_q      = exp_addr_i;
        refill_seen = 1'b0;
        valid_cyc   = 0;
        cyc         = 0;
      end
    end
  end

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source
// 100 ns clock period, reset held for the first 5 cycles

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Released on a falling edge like the rest of the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== icache_top.sv ====
// Two-way L1 instruction cache top
// Control FSM, command decoder, replacement, hit logic and per-way memories

`timescale 1ns/10ps

module icache_top (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Fetch side
  input  logic                                  req_i,
  input  logic [icache_pkg::ICACHE_ADDR_W-1:0]  req_addr_i,
  input  logic                                  flush_i,
  output logic                                  busy_o,
  output logic                                  resp_valid_o,
  output icache_pkg::icache_line_t              resp_line_o,
  // Next memory level
  output logic                                  mem_req_o,
  output logic [icache_pkg::ICACHE_ADDR_W-1:0]  mem_addr_o,
  input  logic                                  mem_valid_i,
  input  icache_pkg::icache_line_t              mem_line_i
);

  import icache_pkg::*;

  icache_ctrl_e            cond_ctrl;
  logic                    mem_ctrl_en;
  logic                    repl_update;
  logic                    hit;
  logic [ICACHE_IDX_W-1:0] index;
  logic [ICACHE_TAG_W-1:0] tag;
  logic [ICACHE_WAYS-1:0]  dmem_cs, dmem_we, tvmem_cs, tvmem_we;
  logic [ICACHE_WAYS-1:0]  valid_vec;
  icache_replace_vec_t     replace_vec;
  icache_tv_t              tv_rdata [ICACHE_WAYS];
  icache_line_t            line_rdata [ICACHE_WAYS];
  icache_tv_t              tv_wdata;
  icache_line_t            hit_line;
  icache_line_t            refill_line_q;

  // Refill line kept for the write cycle and the response
  always_ff @(posedge clk_i) begin
    if (mem_valid_i) begin
      refill_line_q <= mem_line_i;
    end
  end

  // Invalidate writes zeros, refill writes the tag with valid set
  assign tv_wdata    = (cond_ctrl == InvalidSet) ? '0 : icache_tv_t'{valid: 1'b1, tag: tag};
  // Refill address rebuilt from the held tag and index
  assign mem_addr_o  = {tag, index};
  assign resp_line_o = repl_update ? refill_line_q : hit_line;

  icache_ctrl_unit u_ctrl_unit (
    .clk_i, .rst_i, .req_i, .flush_i, .mem_valid_i, .req_addr_i,
    .hit_i(hit), .busy_o, .resp_valid_o, .mem_req_o,
    .mem_ctrl_en_o(mem_ctrl_en), .repl_update_o(repl_update),
    .cond_ctrl_o(cond_ctrl), .index_o(index), .tag_o(tag)
  );

  icache_mem_ctrl u_mem_ctrl (
    .cond_ctrl_i(cond_ctrl), .mem_ctrl_en_i(mem_ctrl_en), .replace_vec_i(replace_vec),
    .dmem_cs_o(dmem_cs), .dmem_we_o(dmem_we), .tvmem_cs_o(tvmem_cs), .tvmem_we_o(tvmem_we)
  );

  icache_replace u_replace (
    .clk_i, .rst_i, .index_i(index), .valid_vec_i(valid_vec),
    .update_i(repl_update), .replace_vec_o(replace_vec)
  );

  icache_hit_logic u_hit_logic (
    .tag_i(tag), .tv_i(tv_rdata), .line_i(line_rdata),
    .hit_o(hit), .valid_vec_o(valid_vec), .line_o(hit_line)
  );

  // One data memory and one tag/valid memory per way
  for (genvar w = 0; w < ICACHE_WAYS; w++) begin : g_way
    icache_sram #(.payload_t(icache_line_t)) u_dmem (
      .clk_i, .cs_i(dmem_cs[w]), .we_i(dmem_we[w]), .addr_i(index),
      .wdata_i(refill_line_q), .rdata_o(line_rdata[w])
    );
    icache_sram #(.payload_t(icache_tv_t)) u_tvmem (
      .clk_i, .cs_i(tvmem_cs[w]), .we_i(tvmem_we[w]), .addr_i(index),
      .wdata_i(tv_wdata), .rdata_o(tv_rdata[w])
    );
  end

endmodule

// ==== icache_ctrl_unit.sv ====
// Cache control FSM
// Sequences lookup, refill, line write and the flush sweep

`timescale 1ns/10ps

module icache_ctrl_unit (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  req_i,
  input  logic                                  flush_i,
  input  logic                                  mem_valid_i,
  input  logic [icache_pkg::ICACHE_ADDR_W-1:0]  req_addr_i,
  input  logic                                  hit_i,
  output logic                                  busy_o,
  output logic                                  resp_valid_o,
  output logic                                  mem_req_o,
  output logic                                  mem_ctrl_en_o,
  output logic                                  repl_update_o,
  output icache_pkg::icache_ctrl_e              cond_ctrl_o,
  output logic [icache_pkg::ICACHE_IDX_W-1:0]   index_o,
  output logic [icache_pkg::ICACHE_TAG_W-1:0]   tag_o
);

  import icache_pkg::*;

  typedef enum logic [2:0] {
    Flush,
    Idle,
    Lookup,
    Compare,
    WaitRefill,
    Write
  } state_e;

  state_e                   state_q, state_d;
  // Request line address, held for the whole operation
  logic [ICACHE_ADDR_W-1:0] addr_q;
  // Set counter for the flush sweep
  logic [ICACHE_IDX_W-1:0]  cnt_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Last set cleared, back to idle
      Flush:      if (cnt_q == ICACHE_IDX_W'(ICACHE_SETS - 1)) state_d = Idle;
      // Flush wins over a simultaneous request
      Idle: begin
        if (flush_i) begin
          state_d = Flush;
        end else if (req_i) begin
          state_d = Lookup;
        end
      end
      Lookup:     state_d = Compare;
      Compare:    state_d = hit_i ? Idle : WaitRefill;
      WaitRefill: if (mem_valid_i) state_d = Write;
      Write:      state_d = Idle;
      default:    state_d = Idle;
    endcase
  end

  // Reset enters the flush sweep so every valid bit starts cleared
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Flush;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Counts only while sweeping, wraps to zero after the last set
      if (state_q == Flush) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  // Capture the address with the request pulse
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && req_i) begin
      addr_q <= req_addr_i;
    end
  end

  // Memory command per state
  always_comb begin
    case (state_q)
      Lookup:  cond_ctrl_o = ReadSet;
      Write:   cond_ctrl_o = WriteLineAndTag;
      Flush:   cond_ctrl_o = InvalidSet;
      default: cond_ctrl_o = NoCtrl;
    endcase
  end

  assign mem_ctrl_en_o = (cond_ctrl_o != NoCtrl);
  assign busy_o        = (state_q != Idle);
  // Hit answers in Compare, miss answers with the refill line
  assign resp_valid_o  = (state_q == Compare && hit_i) || (state_q == Write);
  assign mem_req_o     = (state_q == Compare) && !hit_i;
  assign repl_update_o = (state_q == Write);
  // Sweep index while flushing, request index otherwise
  assign index_o       = (state_q == Flush) ? cnt_q : addr_q[ICACHE_IDX_W-1:0];
  assign tag_o         = addr_q[ICACHE_ADDR_W-1:ICACHE_IDX_W];

  // Fetch side has no back-pressure, new work only while idle
  a_no_req_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) busy_o |-> !(req_i || flush_i))
    else $error("request or flush while cache busy");

endmodule

// ==== icache_hit_logic.sv ====
// Tag compare and hit line select
// One comparator per way, valid entries only

`timescale 1ns/10ps

module icache_hit_logic (
  input  logic [icache_pkg::ICACHE_TAG_W-1:0]  tag_i,
  input  icache_pkg::icache_tv_t               tv_i [icache_pkg::ICACHE_WAYS],
  input  icache_pkg::icache_line_t             line_i [icache_pkg::ICACHE_WAYS],
  output logic                                 hit_o,
  output logic [icache_pkg::ICACHE_WAYS-1:0]   valid_vec_o,
  output icache_pkg::icache_line_t             line_o
);

  import icache_pkg::*;

  logic [ICACHE_WAYS-1:0] hit_vec;

  always_comb begin
    line_o = '0;
    for (int k = 0; k < ICACHE_WAYS; k++) begin
      valid_vec_o[k] = tv_i[k].valid;
      // Tag match counts only on a valid entry
      hit_vec[k]     = tv_i[k].valid && (tv_i[k].tag == tag_i);
      // Line of the hitting way, zero on miss
      if (hit_vec[k]) begin
        line_o = line_i[k];
      end
    end
  end

  assign hit_o = |hit_vec;

  // A refill never duplicates a resident tag, so two hits mean corruption
  always_comb begin
    if (!$isunknown(hit_vec)) begin
      a_single_hit: assert final ($onehot0(hit_vec))
        else $error("tag hit in more than one way");
    end
  end

endmodule

// ==== icache_replace.sv ====
// Refill way selection
// Lowest invalid way first, otherwise a per-set round-robin bit

`timescale 1ns/10ps

module icache_replace (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [icache_pkg::ICACHE_IDX_W-1:0]  index_i,
  input  logic [icache_pkg::ICACHE_WAYS-1:0]   valid_vec_i,
  input  logic                                 update_i,
  output icache_pkg::icache_replace_vec_t      replace_vec_o
);

  import icache_pkg::*;

  // One round-robin bit per set, names the next victim
  logic [ICACHE_SETS-1:0] rr_q;
  logic                   all_valid;

  assign all_valid = &valid_vec_i;

  always_comb begin : pick_way
    logic found;
    found         = 1'b0;
    replace_vec_o = '0;
    // Prefer the lowest invalid way
    for (int k = 0; k < ICACHE_WAYS; k++) begin
      if (!valid_vec_i[k] && !found) begin
        replace_vec_o[k] = 1'b1;
        found            = 1'b1;
      end
    end
    // Full set, victim from the round-robin bit
    if (!found) begin
      replace_vec_o = icache_replace_vec_t'(1) << rr_q[index_i];
    end
  end

  // Advance only when a full set was refilled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else if (update_i && all_valid) begin
      rr_q[index_i] <= ~rr_q[index_i];
    end
  end

endmodule

// ==== icache_mem_ctrl.sv ====
// Cache memory command decoder
// Expands the control unit command into per-way chip-select and write-enable

`timescale 1ns/10ps

module icache_mem_ctrl (
  // Command from the control unit
  input  icache_pkg::icache_ctrl_e             cond_ctrl_i,
  // Command qualifier
  input  logic                                 mem_ctrl_en_i,
  // Way picked by the replacement block
  input  icache_pkg::icache_replace_vec_t      replace_vec_i,
  // Data memories
  output logic [icache_pkg::ICACHE_WAYS-1:0]   dmem_cs_o,
  output logic [icache_pkg::ICACHE_WAYS-1:0]   dmem_we_o,
  // Tag/valid memories
  output logic [icache_pkg::ICACHE_WAYS-1:0]   tvmem_cs_o,
  output logic [icache_pkg::ICACHE_WAYS-1:0]   tvmem_we_o
);

  import icache_pkg::*;

  always_comb begin
    // Nothing selected unless enabled
    dmem_cs_o  = '0;
    dmem_we_o  = '0;
    tvmem_cs_o = '0;
    tvmem_we_o = '0;
    if (mem_ctrl_en_i) begin
      case (cond_ctrl_i)
        // Read all ways of the set for the tag compare
        ReadSet: begin
          dmem_cs_o  = '1;
          tvmem_cs_o = '1;
        end
        // Refill only the replaced way, line and tag together
        WriteLineAndTag: begin
          dmem_cs_o  = replace_vec_i;
          dmem_we_o  = replace_vec_i;
          tvmem_cs_o = replace_vec_i;
          tvmem_we_o = replace_vec_i;
        end
        // Flush clears tag/valid of every way, data untouched
        InvalidSet: begin
          tvmem_cs_o = '1;
          tvmem_we_o = '1;
        end
        default: ;
      endcase
    end
  end

  // A refill must never write two ways or none
  always_comb begin
    if (mem_ctrl_en_i && cond_ctrl_i == WriteLineAndTag) begin
      a_repl_onehot: assert final ($onehot(replace_vec_i))
        else $error("replacement vector not one-hot on refill write");
    end
  end

endmodule

// ==== icache_sram.sv ====
// Single-port synchronous cache memory, one entry per set
// Payload type selects data line or tag/valid storage

`timescale 1ns/10ps

module icache_sram #(
  parameter type payload_t = icache_pkg::icache_line_t
) (
  input  logic                            clk_i,
  input  logic                            cs_i,
  input  logic                            we_i,
  input  logic [icache_pkg::ICACHE_IDX_W-1:0] addr_i,
  input  payload_t                        wdata_i,
  output payload_t                        rdata_o
);

  import icache_pkg::*;

  // Storage array
  payload_t mem_q [ICACHE_SETS];

  // Write when selected with we, else registered read
  // Read data holds its value while not selected
  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

  // Control unit must drive a known set index on every access
  a_addr_known: assert property (@(posedge clk_i) cs_i |-> !$isunknown(addr_i))
    else $error("sram access with unknown address");

endmodule

// ==== icache_pkg.sv ====
// L1 instruction cache shared definitions
// Geometry, decoder command encoding and stored entry types

package icache_pkg;

  // Two-way set associative, 16 sets
  localparam int ICACHE_WAYS = 2;
  localparam int ICACHE_SETS = 16;
  localparam int ICACHE_IDX_W = 4;

  // Line address is the byte address without the 3 offset bits
  localparam int ICACHE_ADDR_W = 29;
  // Tag is what is left above the index
  localparam int ICACHE_TAG_W = 25;
  // One 64-bit instruction line per entry
  localparam int ICACHE_LINE_W = 64;

  // Command from the control unit to the memory decoder
  typedef enum logic [1:0] {
    NoCtrl,
    ReadSet,
    WriteLineAndTag,
    InvalidSet
  } icache_ctrl_e;

  // One-hot way selected for refill
  typedef logic [ICACHE_WAYS-1:0] icache_replace_vec_t;

  // Tag/valid entry, 26 bits
  typedef struct packed {
    logic                    valid;
    logic [ICACHE_TAG_W-1:0] tag;
  } icache_tv_t;

  // Stored instruction line
  typedef logic [ICACHE_LINE_W-1:0] icache_line_t;

endpackage
